// ==== design/up_pkg.sv ====
package up_pkg;

   localparam int DATA_W     = 8;
   localparam int MEM_DEPTH  = 256;
   localparam int MAP_ADDR_W = 9;

   localparam logic [DATA_W-1:0] PC_RESET = 8'h08;   // Nibble address of first opcode
   localparam logic [DATA_W-1:0] SP_RESET = 8'hFF;

   // Readback offsets, host address bit 8 set
   localparam logic [DATA_W-1:0] MAP_R0    = 8'h00;
   localparam logic [DATA_W-1:0] MAP_R1    = 8'h01;
   localparam logic [DATA_W-1:0] MAP_R2    = 8'h02;
   localparam logic [DATA_W-1:0] MAP_R3    = 8'h03;
   localparam logic [DATA_W-1:0] MAP_PC    = 8'h04;
   localparam logic [DATA_W-1:0] MAP_SP    = 8'h05;
   localparam logic [DATA_W-1:0] MAP_STATE = 8'h06;

   typedef enum logic [3:0] {
      OP_ADD   = 4'h0,
      OP_SUB   = 4'h1,
      OP_MUL   = 4'h2,
      OP_NAND  = 4'h3,
      OP_SW01  = 4'h4,
      OP_SW12  = 4'h5,
      OP_SW23  = 4'h6,
      OP_BE    = 4'h7,
      OP_POPC  = 4'h8,
      OP_PUSHC = 4'h9,
      OP_POP   = 4'hA,
      OP_PUSH  = 4'hB,
      OP_LDW   = 4'hC,
      OP_STW   = 4'hD,
      OP_REF   = 4'hE,
      OP_NOP   = 4'hF
   } opcode_e;

   typedef enum logic [3:0] {
      LOAD_0, LOAD_1, LOAD_2, LOAD_3, LOAD_4,
      FETCH, DECODE,
      EXEC_1, EXEC_2, EXEC_3
   } state_e;

   typedef enum logic [4:0] {
      BUS_ZERO, BUS_INDEX,
      BUS_FETCH_ADDR, BUS_PC_INC, BUS_PC,
      BUS_ADD, BUS_SUB, BUS_MUL, BUS_NAND,
      BUS_XOR01, BUS_XOR12, BUS_XOR23,
      BUS_R2, BUS_R3,
      BUS_SP, BUS_SP_INC, BUS_SP_DEC,
      BUS_MEM
   } bus_src_e;

   typedef struct packed {
      bus_src_e   bus_src;
      logic [1:0] byte_index;     // Constant for BUS_INDEX
      logic       reg_from_bus;   // 0 takes the memory byte
      logic [1:0] reg_index;
      logic       reg_we;
      logic       ir_we;
      logic       pc_we;
      logic       sp_we;
      logic       ale;
      logic       mem_we;
   } ctrl_t;

   typedef struct packed {
      logic [DATA_W-1:0] r0;
      logic [DATA_W-1:0] r1;
      logic [DATA_W-1:0] r2;
      logic [DATA_W-1:0] r3;
      logic [DATA_W-1:0] pc;
      logic [DATA_W-1:0] sp;
   } regs_t;

endpackage

// ==== design/up_control.sv ====
`timescale 1ns/1ps

module up_control import up_pkg::*; (
   input  logic    clk,
   input  logic    nRst,
   input  logic    restart,
   input  opcode_e ir,
   input  logic    equal,
   output ctrl_t   ctrl,
   output state_e  state
);

   state_e     next_state;
   logic       long_op;
   logic       five_op;
   bus_src_e   swap_src;
   logic [1:0] swap_lo;

   assign long_op = !(ir inside {OP_ADD, OP_SUB, OP_MUL, OP_NAND, OP_BE, OP_NOP});
   assign five_op = ir inside {OP_SW01, OP_SW12, OP_SW23, OP_PUSH, OP_PUSHC};

   // XOR swap pair, lower register index follows the opcode
   assign swap_lo = ir[1:0];

   always_comb begin
      unique case (ir)
         OP_SW12: swap_src = BUS_XOR12;
         OP_SW23: swap_src = BUS_XOR23;
         default: swap_src = BUS_XOR01;
      endcase
   end

   always_comb begin
      unique case (state)
         LOAD_0:  next_state = LOAD_1;
         LOAD_1:  next_state = LOAD_2;
         LOAD_2:  next_state = LOAD_3;
         LOAD_3:  next_state = LOAD_4;
         LOAD_4:  next_state = FETCH;
         FETCH:   next_state = DECODE;
         DECODE:  next_state = EXEC_1;
         EXEC_1:  next_state = long_op ? EXEC_2 : FETCH;
         EXEC_2:  next_state = five_op ? EXEC_3 : FETCH;
         default: next_state = FETCH;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst)
         state <= LOAD_0;
      else if (restart)
         state <= LOAD_0;            // Soft restart from host
      else
         state <= next_state;
   end

   always_comb begin
      ctrl              = '0;
      ctrl.bus_src      = BUS_ZERO;
      ctrl.reg_from_bus = 1'b1;
      unique case (state)
         LOAD_0: begin
            ctrl.bus_src    = BUS_INDEX;
            ctrl.byte_index = 2'd0;
            ctrl.ale        = 1'b1;
         end
         LOAD_1, LOAD_2, LOAD_3: begin
            ctrl.bus_src      = BUS_INDEX;
            ctrl.byte_index   = state[1:0];          // Address of next preload byte
            ctrl.reg_index    = state[1:0] - 2'd1;
            ctrl.reg_from_bus = 1'b0;
            ctrl.reg_we       = 1'b1;
            ctrl.ale          = 1'b1;
         end
         LOAD_4: begin
            ctrl.bus_src      = BUS_FETCH_ADDR;
            ctrl.reg_index    = 2'd3;
            ctrl.reg_from_bus = 1'b0;
            ctrl.reg_we       = 1'b1;
            ctrl.ale          = 1'b1;
         end
         FETCH: begin
            ctrl.bus_src = BUS_FETCH_ADDR;
            ctrl.ale     = 1'b1;
         end
         DECODE: begin
            ctrl.bus_src = BUS_PC_INC;
            ctrl.ir_we   = 1'b1;
            ctrl.pc_we   = 1'b1;
         end
         EXEC_1, EXEC_3: begin
            unique case (ir)
               OP_ADD, OP_SUB, OP_MUL, OP_NAND: begin
                  ctrl.bus_src = bus_src_e'(BUS_ADD + ir[1:0]);   // R0 gets the ALU result
                  ctrl.reg_we  = (state == EXEC_1);
               end
               OP_SW01, OP_SW12, OP_SW23: begin
                  ctrl.bus_src   = swap_src;
                  ctrl.reg_index = swap_lo;
                  ctrl.reg_we    = 1'b1;
               end
               OP_BE: begin
                  ctrl.bus_src = BUS_R3;
                  ctrl.pc_we   = equal && (state == EXEC_1);
               end
               OP_POP, OP_POPC: begin
                  ctrl.bus_src = BUS_SP_INC;
                  ctrl.sp_we   = 1'b1;
                  ctrl.ale     = 1'b1;
               end
               OP_PUSH, OP_PUSHC: begin
                  if (state == EXEC_1) begin
                     ctrl.bus_src = BUS_SP;
                     ctrl.ale     = 1'b1;
                  end else begin
                     ctrl.bus_src = (ir == OP_PUSH) ? BUS_R2 : BUS_PC;
                     ctrl.mem_we  = 1'b1;
                  end
               end
               OP_LDW, OP_STW: begin
                  ctrl.bus_src = BUS_R3;
                  ctrl.ale     = 1'b1;
               end
               OP_REF: begin
                  ctrl.bus_src = BUS_INDEX;
                  ctrl.ale     = 1'b1;
               end
               OP_NOP: ;
               default: ;
            endcase
         end
         EXEC_2: begin
            unique case (ir)
               OP_SW01, OP_SW12, OP_SW23: begin
                  ctrl.bus_src   = swap_src;
                  ctrl.reg_index = swap_lo + 2'd1;
                  ctrl.reg_we    = 1'b1;
               end
               OP_POPC: begin
                  ctrl.bus_src = BUS_MEM;
                  ctrl.pc_we   = 1'b1;
               end
               OP_PUSH, OP_PUSHC: begin
                  ctrl.bus_src = BUS_SP_DEC;
                  ctrl.sp_we   = 1'b1;
               end
               OP_POP, OP_LDW, OP_REF: begin
                  ctrl.reg_index    = (ir == OP_REF) ? 2'd0 : 2'd2;
                  ctrl.reg_from_bus = 1'b0;
                  ctrl.reg_we       = 1'b1;
               end
               OP_STW: begin
                  ctrl.bus_src = BUS_R2;
                  ctrl.mem_we  = 1'b1;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

   assert property (@(posedge clk) disable iff (!nRst) !(ctrl.ale && ctrl.mem_we));
   assert property (@(posedge clk) disable iff (!nRst)
      state inside {LOAD_0, LOAD_1, LOAD_2, LOAD_3, LOAD_4, FETCH, DECODE,
                    EXEC_1, EXEC_2, EXEC_3});

endmodule

// ==== design/up_datapath.sv ====
`timescale 1ns/1ps

module up_datapath import up_pkg::*; (
   input  logic              clk,
   input  logic              nRst,
   input  logic              restart,
   input  ctrl_t             ctrl,
   input  logic [DATA_W-1:0] mem_rdata,
   output logic [DATA_W-1:0] bus,
   output logic [DATA_W-1:0] addr,
   output opcode_e           ir,
   output logic              equal,
   output regs_t             regs
);

   logic [DATA_W-1:0] gp [4];      // R0 to R3
   logic [DATA_W-1:0] pc;
   logic [DATA_W-1:0] sp;
   logic [DATA_W-1:0] reg_wdata;
   opcode_e           ir_next;

   assign equal     = (gp[1] == gp[2]);
   assign reg_wdata = ctrl.reg_from_bus ? bus : mem_rdata;
   assign ir_next   = pc[0] ? opcode_e'(mem_rdata[3:0]) : opcode_e'(mem_rdata[7:4]);
   assign regs      = {gp[0], gp[1], gp[2], gp[3], pc, sp};

   always_comb begin
      unique case (ctrl.bus_src)
         BUS_INDEX:      bus = DATA_W'(ctrl.byte_index);
         BUS_FETCH_ADDR: bus = {1'b0, pc[DATA_W-1:1]};   // Byte holding the next nibble
         BUS_PC_INC:     bus = pc + 8'd1;
         BUS_PC:         bus = pc;
         BUS_ADD:        bus = gp[1] + gp[2];
         BUS_SUB:        bus = gp[1] - gp[2];
         BUS_MUL:        bus = gp[1] * gp[2];
         BUS_NAND:       bus = ~(gp[1] & gp[2]);
         BUS_XOR01:      bus = gp[0] ^ gp[1];
         BUS_XOR12:      bus = gp[1] ^ gp[2];
         BUS_XOR23:      bus = gp[2] ^ gp[3];
         BUS_R2:         bus = gp[2];
         BUS_R3:         bus = gp[3];
         BUS_SP:         bus = sp;
         BUS_SP_INC:     bus = sp + 8'd1;
         BUS_SP_DEC:     bus = sp - 8'd1;
         BUS_MEM:        bus = mem_rdata;
         default:        bus = '0;
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         for (int i = 0; i < 4; i++) begin
            gp[i] <= '0;
         end
         pc   <= PC_RESET;
         sp   <= SP_RESET;
         ir   <= OP_ADD;
         addr <= '0;
      end else if (restart) begin
         for (int i = 0; i < 4; i++) begin
            gp[i] <= '0;
         end
         pc   <= PC_RESET;
         sp   <= SP_RESET;
         ir   <= OP_ADD;
         addr <= '0;
      end else begin
         if (ctrl.reg_we)
            gp[ctrl.reg_index] <= reg_wdata;
         if (ctrl.pc_we)
            pc <= bus;
         if (ctrl.sp_we)
            sp <= bus;
         if (ctrl.ir_we)
            ir <= ir_next;              // Uses PC before the DECODE increment
         if (ctrl.ale)
            addr <= bus;
      end
   end

   // Memory loads into registers always take the direct path
   assert property (@(posedge clk) disable iff (!nRst)
      (ctrl.reg_we && !ctrl.reg_from_bus) |-> (ctrl.bus_src != BUS_MEM));

endmodule

// ==== design/up_memory_map.sv ====
`timescale 1ns/1ps

module up_memory_map import up_pkg::*; (
   input  logic                  clk,
   input  logic                  host_load,
   input  logic [MAP_ADDR_W-1:0] host_address,
   input  logic [DATA_W-1:0]     host_wdata,
   output logic [DATA_W-1:0]     host_rdata,
   input  logic [DATA_W-1:0]     addr,
   input  logic [DATA_W-1:0]     bus,
   input  logic                  mem_we,
   input  regs_t                 regs,
   input  state_e                state,
   output logic [DATA_W-1:0]     mem_rdata,
   output logic                  restart
);

   logic [DATA_W-1:0] mem [MEM_DEPTH];
   logic              map_sel;
   logic [DATA_W-1:0] host_index;

   assign map_sel    = host_address[MAP_ADDR_W-1];   // Upper half is register readback
   assign host_index = host_address[DATA_W-1:0];
   assign restart    = host_load && map_sel;
   assign mem_rdata  = mem[addr];

   always_ff @(posedge clk) begin
      if (mem_we)
         mem[addr] <= bus;
      if (host_load && !map_sel)
         mem[host_index] <= host_wdata;   // Host wins a same-edge collision
   end

   always_comb begin
      if (!map_sel) begin
         host_rdata = mem[host_index];
      end else begin
         unique case (host_index)
            MAP_R0:    host_rdata = regs.r0;
            MAP_R1:    host_rdata = regs.r1;
            MAP_R2:    host_rdata = regs.r2;
            MAP_R3:    host_rdata = regs.r3;
            MAP_PC:    host_rdata = regs.pc;
            MAP_SP:    host_rdata = regs.sp;
            MAP_STATE: host_rdata = DATA_W'(state);
            default:   host_rdata = '0;
         endcase
      end
   end

   // A restart lands the sequencer in LOAD_0
   assert property (@(posedge clk) restart |=> (state == LOAD_0));

endmodule

// ==== design/up_core.sv ====
`timescale 1ns/1ps

module up_core import up_pkg::*; (
   input  logic                  clk,
   input  logic                  nRst,
   input  logic                  host_load,
   input  logic [MAP_ADDR_W-1:0] host_address,
   input  logic [DATA_W-1:0]     host_wdata,
   output logic [DATA_W-1:0]     host_rdata
);

   ctrl_t             ctrl;
   state_e            state;
   opcode_e           ir;
   regs_t             regs;
   logic              equal;
   logic              restart;
   logic [DATA_W-1:0] bus;
   logic [DATA_W-1:0] addr;
   logic [DATA_W-1:0] mem_rdata;

   up_control u_control (
      .clk, .nRst, .restart, .ir, .equal, .ctrl, .state
   );

   up_datapath u_datapath (
      .clk, .nRst, .restart, .ctrl, .mem_rdata, .bus, .addr, .ir, .equal, .regs
   );

   up_memory_map u_memory_map (
      .clk,
      .host_load,
      .host_address,
      .host_wdata,
      .host_rdata,
      .addr,
      .bus,
      .mem_we (ctrl.mem_we),
      .regs,
      .state,
      .mem_rdata,
      .restart
   );

endmodule

// ==== testbench/up_core_tb.sv ====
`timescale 1ns/1ps

module up_core_tb import up_pkg::*; ();

   localparam int  HALF_PERIOD = 2;
   localparam real READ_DELAY  = 0.2;    // Up to eight readbacks fit in one low phase
   localparam int  MAX_CYCLES  = 3000;   // Whole run needs well under 1500
   localparam int  LOAD_CYCLES = 5;
   localparam int  ALU_CYCLES  = 3;
   localparam int  MEM_CYCLES  = 4;
   localparam int  SWAP_CYCLES = 5;

   localparam logic [MAP_ADDR_W-1:0] RD_R0        = {1'b1, MAP_R0};
   localparam logic [MAP_ADDR_W-1:0] RD_R1        = {1'b1, MAP_R1};
   localparam logic [MAP_ADDR_W-1:0] RD_R2        = {1'b1, MAP_R2};
   localparam logic [MAP_ADDR_W-1:0] RD_R3        = {1'b1, MAP_R3};
   localparam logic [MAP_ADDR_W-1:0] RD_PC        = {1'b1, MAP_PC};
   localparam logic [MAP_ADDR_W-1:0] RD_SP        = {1'b1, MAP_SP};
   localparam logic [MAP_ADDR_W-1:0] RD_STATE     = {1'b1, MAP_STATE};
   localparam logic [MAP_ADDR_W-1:0] RESTART_ADDR = 9'h100;

   logic                  clk;
   logic                  nRst;
   logic                  host_load;
   logic [MAP_ADDR_W-1:0] host_address;
   logic [DATA_W-1:0]     host_wdata;
   logic [DATA_W-1:0]     host_rdata;
   int                    cycle_count = 0;

   up_core dut (
      .clk,
      .nRst,
      .host_load,
      .host_address,
      .host_wdata,
      .host_rdata
   );

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
         $display("SIMULATION FAILED");
         $fatal(1, "Cycle limit reached");
      end
   end

   // All tasks start and end just after a falling edge
   task automatic host_write(input logic [MAP_ADDR_W-1:0] address,
                             input logic [DATA_W-1:0] data);
      host_load    = 1'b1;
      host_address = address;
      host_wdata   = data;
      @(negedge clk);
      host_load    = 1'b0;
   endtask

   task automatic restart();
      host_write(RESTART_ADDR, '0);
   endtask

   task automatic run_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic host_read(input logic [MAP_ADDR_W-1:0] address,
                            output logic [DATA_W-1:0] data);
      host_address = address;
      #(READ_DELAY);
      data = host_rdata;
   endtask

   task automatic check(input string test_name, input logic [DATA_W-1:0] expected,
                        input logic [DATA_W-1:0] actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected 0x%02h, actual 0x%02h", test_name, expected, actual);
         $display("SIMULATION FAILED");
         $fatal(1, "Mismatch in %s", test_name);
      end
   endtask

   task automatic check_readback(input string test_name,
                                 input logic [MAP_ADDR_W-1:0] address,
                                 input logic [DATA_W-1:0] expected);
      logic [DATA_W-1:0] data;
      host_read(address, data);
      check(test_name, expected, data);
   endtask

   task automatic check_regs(input string test_name, input logic [DATA_W-1:0] e0,
                             input logic [DATA_W-1:0] e1, input logic [DATA_W-1:0] e2,
                             input logic [DATA_W-1:0] e3);
      check_readback({test_name, " R0"}, RD_R0, e0);
      check_readback({test_name, " R1"}, RD_R1, e1);
      check_readback({test_name, " R2"}, RD_R2, e2);
      check_readback({test_name, " R3"}, RD_R3, e3);
   endtask

   function automatic logic [DATA_W-1:0] fill_byte(input logic [DATA_W-1:0] a);
      return (a * 8'd37) ^ 8'hA5;   // Odd multiplier keeps every address distinct
   endfunction

   // Core sits in reset while bytes 0 to 7 are written
   task automatic load_program(input logic [DATA_W-1:0] regs_init [4],
                               input logic [DATA_W-1:0] code [4]);
      @(negedge clk);
      nRst = 1'b0;
      for (int i = 0; i < 4; i++) begin
         host_write(MAP_ADDR_W'(i), regs_init[i]);
         host_write(MAP_ADDR_W'(i + 4), code[i]);
      end
   endtask

   task automatic start_core();
      nRst = 1'b1;
      restart();
      run_cycles(LOAD_CYCLES);   // Preload done, FETCH next
   endtask

   task automatic reset_and_preload();
      logic [DATA_W-1:0] r [4];
      logic [DATA_W-1:0] code [4];
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] fresh;
      for (int i = 0; i < 4; i++)
         r[i] = DATA_W'($urandom());
      code = '{8'hFF, 8'hFF, 8'hFF, 8'hFF};
      load_program(r, code);
      for (int i = 0; i < 8; i++) begin
         a = 8'h40 + DATA_W'(i);
         host_write({1'b0, a}, fill_byte(a));
      end
      check_regs("reset", '0, '0, '0, '0);
      check_readback("reset PC", RD_PC, PC_RESET);
      check_readback("reset SP", RD_SP, SP_RESET);
      check_readback("unmapped offset", {1'b1, 8'h07}, '0);
      for (int i = 0; i < 8; i++) begin
         a = 8'h40 + DATA_W'(i);
         check_readback("memory readback", {1'b0, a}, fill_byte(a));
         run_cycles(1);
      end
      start_core();
      check_regs("preload", r[0], r[1], r[2], r[3]);
      check_readback("preload PC", RD_PC, PC_RESET);
      check_readback("preload SP", RD_SP, SP_RESET);
      check_readback("preload state", RD_STATE, DATA_W'(FETCH));
      fresh = ~r[0];
      run_cycles(1);
      host_write(9'h000, fresh);   // New byte 0 seen only after a restart
      restart();
      run_cycles(LOAD_CYCLES);
      check_regs("soft restart", fresh, r[1], r[2], r[3]);
   endtask

   task automatic arithmetic_ops();
      logic [DATA_W-1:0]   r [4];
      logic [DATA_W-1:0]   code [4];
      logic [2*DATA_W-1:0] product;
      for (int i = 0; i < 4; i++)
         r[i] = DATA_W'($urandom());
      code    = '{8'h01, 8'h23, 8'hFF, 8'hFF};   // ADD SUB MUL NAND
      product = {{DATA_W{1'b0}}, r[1]} * {{DATA_W{1'b0}}, r[2]};
      load_program(r, code);
      start_core();
      run_cycles(ALU_CYCLES);
      check_readback("ADD", RD_R0, r[1] + r[2]);
      run_cycles(ALU_CYCLES);
      check_readback("SUB", RD_R0, r[1] - r[2]);
      run_cycles(ALU_CYCLES);
      check_readback("MUL", RD_R0, product[DATA_W-1:0]);
      run_cycles(ALU_CYCLES);
      check_readback("NAND", RD_R0, ~(r[1] & r[2]));
      check_readback("NAND PC", RD_PC, PC_RESET + 8'd4);
   endtask

   task automatic register_swaps();
      logic [DATA_W-1:0] r [4];
      logic [DATA_W-1:0] code [4];
      logic [DATA_W-1:0] tmp;
      for (int i = 0; i < 4; i++)
         r[i] = DATA_W'($urandom());
      code = '{8'h45, 8'h6F, 8'hFF, 8'hFF};   // SW01 SW12 SW23
      load_program(r, code);
      start_core();
      for (int k = 0; k < 3; k++) begin
         tmp      = r[k];
         r[k]     = r[k + 1];
         r[k + 1] = tmp;
         run_cycles(SWAP_CYCLES);
         check_regs($sformatf("SW%0d%0d", k, k + 1), r[0], r[1], r[2], r[3]);
      end
   endtask

   task automatic memory_access();
      logic [DATA_W-1:0] r [4];
      logic [DATA_W-1:0] code [4];
      logic [DATA_W-1:0] loaded;
      r[0]   = DATA_W'($urandom());
      r[1]   = DATA_W'($urandom());
      r[2]   = 8'h40 | (DATA_W'($urandom()) & 8'h3F);   // Also the LDW address after SW23
      r[3]   = 8'h80 | (DATA_W'($urandom()) & 8'h7F);   // STW address
      loaded = DATA_W'($urandom());
      code   = '{8'hD6, 8'hC0, 8'hEF, 8'hFF};   // STW SW23 LDW ADD REF
      load_program(r, code);
      host_write({1'b0, r[3]}, ~r[2]);
      host_write({1'b0, r[2]}, loaded);
      start_core();
      run_cycles(MEM_CYCLES);
      check_readback("STW", {1'b0, r[3]}, r[2]);
      run_cycles(SWAP_CYCLES);
      run_cycles(MEM_CYCLES);
      check_readback("LDW", RD_R2, loaded);
      run_cycles(ALU_CYCLES);
      check_readback("ADD after LDW", RD_R0, r[1] + loaded);
      run_cycles(MEM_CYCLES);
      check_readback("REF", RD_R0, r[0]);
   endtask

   task automatic stack_ops();
      logic [DATA_W-1:0] r [4];
      logic [DATA_W-1:0] code [4];
      logic [DATA_W-1:0] pushed_pc;
      for (int i = 0; i < 4; i++)
         r[i] = DATA_W'($urandom());
      r[3]      = ~r[2];
      code      = '{8'hB6, 8'hA9, 8'hF8, 8'hFF};   // PUSH SW23 POP PUSHC NOP POPC
      pushed_pc = PC_RESET + 8'd4;               // Nibble right after PUSHC
      load_program(r, code);
      host_write({1'b0, SP_RESET}, r[2] ^ 8'h81);
      start_core();
      run_cycles(SWAP_CYCLES);
      check_readback("PUSH data", {1'b0, SP_RESET}, r[2]);
      check_readback("PUSH SP", RD_SP, SP_RESET - 8'd1);
      run_cycles(SWAP_CYCLES);
      check_readback("SW23 before POP", RD_R2, r[3]);
      run_cycles(MEM_CYCLES);
      check_readback("POP R2", RD_R2, r[2]);
      check_readback("POP SP", RD_SP, SP_RESET);
      run_cycles(SWAP_CYCLES);
      check_readback("PUSHC data", {1'b0, SP_RESET}, pushed_pc);
      check_readback("PUSHC SP", RD_SP, SP_RESET - 8'd1);
      run_cycles(ALU_CYCLES);
      check_readback("NOP PC", RD_PC, pushed_pc + 8'd1);
      run_cycles(MEM_CYCLES);
      check_readback("POPC PC", RD_PC, pushed_pc);
      check_readback("POPC SP", RD_SP, SP_RESET);
   endtask

   task automatic branch_on_equal();
      logic [DATA_W-1:0] r [4];
      logic [DATA_W-1:0] code [4];
      for (int i = 0; i < 4; i++)
         r[i] = DATA_W'($urandom());
      r[2] = r[1];
      r[3] = 8'h20 | (DATA_W'($urandom()) & 8'h1E);   // Branch target
      code = '{8'h7F, 8'hFF, 8'hFF, 8'hFF};
      load_program(r, code);
      start_core();
      run_cycles(ALU_CYCLES);
      check_readback("BE taken", RD_PC, r[3]);
      r[2] = ~r[1];
      load_program(r, code);
      start_core();
      run_cycles(ALU_CYCLES);
      check_readback("BE not taken", RD_PC, PC_RESET + 8'd1);
   endtask

   initial begin
      void'($urandom(70902));
      nRst         = 1'b0;
      host_load    = 1'b0;
      host_address = '0;
      host_wdata   = '0;
      repeat (2) @(negedge clk);
      nRst = 1'b1;
      reset_and_preload();
      arithmetic_ops();
      register_swaps();
      memory_access();
      stack_ops();
      branch_on_equal();
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== filelist.f ====
design/up_pkg.sv
design/up_control.sv
design/up_datapath.sv
design/up_memory_map.sv
design/up_core.sv
testbench/up_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module up_core_tb -Mdir obj_dir -o up_core_sim -f filelist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_output=$(./obj_dir/up_core_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -q "SIMULATION PASSED"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
